/* bench/back_end_assertions.sv */
/*
 * Concurrent checks on the queue strobes and reset state of the back end.
 * Bound into back_end; the failure count is visible to the testbench.
 */
module back_end_assertions (
	input logic i_clk,
	input logic i_reset,
	input logic i_instr_pop,
	input logic i_rob_push,
	input logic i_rob_full,
	input logic i_rob_pop,
	input logic i_rob_empty,
	input logic i_iq_push,
	input logic i_commit_valid
);

	int failures = 0;

	a_rob_push_space: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rob_push |-> !i_rob_full)
	else begin
		failures++;
		$error("ROB pushed while full");
	end

	// dispatch takes an op only when both queues accept it
	a_pop_pushes_both: assert property (@(posedge i_clk) disable iff (i_reset)
		i_instr_pop |-> (i_rob_push && i_iq_push))
	else begin
		failures++;
		$error("instruction popped without ROB and issue FIFO pushes");
	end

	a_rob_pop_entry: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rob_pop |-> !i_rob_empty)
	else begin
		failures++;
		$error("ROB popped while empty");
	end

	// registered output, so quiet from the edge after reset is seen
	a_reset_quiet: assert property (@(posedge i_clk)
		i_reset |=> !i_commit_valid)
	else begin
		failures++;
		$error("commit valid raised during reset");
	end

endmodule

bind back_end back_end_assertions u_assertions (
	.i_clk(CLK),
	.i_reset(i_reset),
	.i_instr_pop(o_instr_pop),
	.i_rob_push(rob_push),
	.i_rob_full(rob_full),
	.i_rob_pop(rob_pop),
	.i_rob_empty(rob_empty),
	.i_iq_push(iq_push),
	.i_commit_valid(o_commit_valid)
);

/* bench/tb_back_end.sv */
/*
 * Directed testbench for the back end. Models the instruction FIFO,
 * predicts every retirement from a register model and checks each commit.
 */
module tb_back_end;

	logic                          CLK;
	logic                          i_reset;
	logic                          i_instr_empty;
	backend_pkg::alu_op_e          i_op;
	logic [backend_pkg::RA-1:0]    i_rd;
	logic [backend_pkg::RA-1:0]    i_rs1;
	logic [backend_pkg::RA-1:0]    i_rs2;
	logic [backend_pkg::IMM_W-1:0] i_imm;
	logic                          o_instr_pop;
	logic                          o_commit_valid;
	logic [backend_pkg::RA-1:0]    o_commit_rd;
	logic [backend_pkg::XLEN-1:0]  o_commit_data;

	typedef struct packed {
		backend_pkg::alu_op_e          op;
		logic [backend_pkg::RA-1:0]    rd;
		logic [backend_pkg::RA-1:0]    rs1;
		logic [backend_pkg::RA-1:0]    rs2;
		logic [backend_pkg::IMM_W-1:0] imm;
	} instr_t;

	typedef struct packed {
		logic [backend_pkg::RA-1:0]   rd;
		logic [backend_pkg::XLEN-1:0] data;
	} commit_t;

	instr_t                       instr_q[$];
	commit_t                      expected_q[$];
	logic [backend_pkg::XLEN-1:0] ref_regs [backend_pkg::ARCH_REGS];
	int                           seed = 72154;
	int                           sent_count = 0;
	int                           commit_count = 0;
	int                           stall_count = 0;
	int                           cycle_count = 0;
	logic                         gaps_on;

	back_end dut (
		.CLK(CLK),
		.i_reset(i_reset),
		.i_instr_empty(i_instr_empty),
		.i_op(i_op),
		.i_rd(i_rd),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_imm(i_imm),
		.o_instr_pop(o_instr_pop),
		.o_commit_valid(o_commit_valid),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

	always #4 CLK = ~CLK;

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR time=%0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_equal(input string name, input logic [backend_pkg::XLEN-1:0] got,
		input logic [backend_pkg::XLEN-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
			stop_run();
		end
	endtask

	// result by the opcode rule with a sign-extended immediate for ADDI
	function automatic logic [backend_pkg::XLEN-1:0] expected_result(
		input backend_pkg::alu_op_e op, input logic [backend_pkg::XLEN-1:0] a,
		input logic [backend_pkg::XLEN-1:0] b, input logic [backend_pkg::IMM_W-1:0] imm);
		logic [backend_pkg::XLEN-1:0] imm_ext;
		imm_ext = backend_pkg::XLEN'(signed'(imm));
		case (op)
			backend_pkg::OP_ADD:  return a + b;
			backend_pkg::OP_SUB:  return a - b;
			backend_pkg::OP_AND:  return a & b;
			backend_pkg::OP_OR:   return a | b;
			backend_pkg::OP_XOR:  return a ^ b;
			backend_pkg::OP_ADDI: return a + imm_ext;
			default:              return '0;
		endcase
	endfunction

	// queue one op and predict its retirement in program order
	task automatic send_op(input backend_pkg::alu_op_e op, input logic [backend_pkg::RA-1:0] rd,
		input logic [backend_pkg::RA-1:0] rs1, input logic [backend_pkg::RA-1:0] rs2,
		input logic [backend_pkg::IMM_W-1:0] imm);
		instr_t  ins;
		commit_t exp;
		ins.op   = op;
		ins.rd   = rd;
		ins.rs1  = rs1;
		ins.rs2  = rs2;
		ins.imm  = imm;
		exp.rd   = rd;
		exp.data = expected_result(op, ref_regs[rs1], ref_regs[rs2], imm);
		ref_regs[rd] = exp.data;
		instr_q.push_back(ins);
		expected_q.push_back(exp);
		sent_count++;
	endtask

	task automatic present_head();
		if (instr_q.size() == 0) begin
			i_instr_empty = 1'b1;
		end else if (gaps_on && (($random(seed) & 3) == 0)) begin
			i_instr_empty = 1'b1;
		end else begin
			i_instr_empty = 1'b0;
			i_op  = instr_q[0].op;
			i_rd  = instr_q[0].rd;
			i_rs1 = instr_q[0].rs1;
			i_rs2 = instr_q[0].rs2;
			i_imm = instr_q[0].imm;
		end
	endtask

	// wait for every queued op to retire plus a few quiet cycles
	task automatic wait_drain();
		while (instr_q.size() != 0 || expected_q.size() != 0)
			@(posedge CLK);
		repeat (4) @(posedge CLK);
	endtask

	task automatic reset_dut();
		i_reset = 1'b1;
		repeat (8) @(posedge CLK);
		#1;
		i_reset = 1'b0;
	endtask

	task automatic reset_reads_zero();
		repeat (20) @(posedge CLK);
		check_equal("commit_count", commit_count, 0);
		send_op(backend_pkg::OP_ADD, 3'd3, 3'd6, 3'd7, 8'h00);
		send_op(backend_pkg::OP_OR, 3'd2, 3'd4, 3'd5, 8'h11);
		wait_drain();
	endtask

	task automatic opcode_results();
		send_op(backend_pkg::OP_ADDI, 3'd1, 3'd0, 3'd0, 8'h5a);
		send_op(backend_pkg::OP_ADDI, 3'd2, 3'd0, 3'd0, 8'h33);
		send_op(backend_pkg::OP_ADDI, 3'd0, 3'd0, 3'd0, 8'h80);
		send_op(backend_pkg::OP_ADD, 3'd3, 3'd1, 3'd2, 8'h00);
		send_op(backend_pkg::OP_SUB, 3'd4, 3'd1, 3'd2, 8'h00);
		send_op(backend_pkg::OP_AND, 3'd5, 3'd1, 3'd2, 8'h00);
		send_op(backend_pkg::OP_OR, 3'd6, 3'd1, 3'd0, 8'h00);
		send_op(backend_pkg::OP_XOR, 3'd7, 3'd2, 3'd0, 8'h00);
		send_op(backend_pkg::OP_ADDI, 3'd1, 3'd2, 3'd7, 8'hfb);
		wait_drain();
	endtask

	// each op consumes the previous destination
	task automatic raw_chain_values();
		send_op(backend_pkg::OP_ADDI, 3'd1, 3'd1, 3'd0, 8'h07);
		send_op(backend_pkg::OP_ADD, 3'd2, 3'd1, 3'd1, 8'h00);
		send_op(backend_pkg::OP_SUB, 3'd3, 3'd2, 3'd1, 8'h00);
		send_op(backend_pkg::OP_XOR, 3'd4, 3'd3, 3'd2, 8'h00);
		send_op(backend_pkg::OP_AND, 3'd5, 3'd4, 3'd3, 8'h00);
		send_op(backend_pkg::OP_ADDI, 3'd6, 3'd5, 3'd0, 8'hff);
		send_op(backend_pkg::OP_OR, 3'd7, 3'd6, 3'd5, 8'h00);
		wait_drain();
	endtask

	task automatic copy_exhaust_stall();
		int stalls_before;
		stalls_before = stall_count;
		send_op(backend_pkg::OP_ADDI, 3'd5, 3'd0, 3'd0, 8'h0b);
		send_op(backend_pkg::OP_ADDI, 3'd5, 3'd0, 3'd0, 8'h16);
		send_op(backend_pkg::OP_ADDI, 3'd5, 3'd0, 3'd0, 8'h21);
		send_op(backend_pkg::OP_ADDI, 3'd5, 3'd0, 3'd0, 8'h2c);
		send_op(backend_pkg::OP_ADDI, 3'd5, 3'd0, 3'd0, 8'h37);
		send_op(backend_pkg::OP_ADD, 3'd6, 3'd5, 3'd5, 8'h00);
		wait_drain();
		if (stall_count == stalls_before)
			report_failure("dispatch never stalled with five writes to one register in flight");
	endtask

	task automatic random_stream_match();
		logic [31:0] r;
		int          op_idx;
		gaps_on = 1'b0;
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			op_idx = r[31:20] % 6;
			send_op(backend_pkg::alu_op_e'(op_idx[2:0]), r[2:0], r[5:3], r[8:6], r[16:9]);
		end
		gaps_on = 1'b1;
		wait_drain();
		gaps_on = 1'b0;
	endtask

	// instruction FIFO model that advances on the pop sampled before the edge
	initial begin : instr_driver
		logic popped;
		forever begin
			@(negedge CLK);
			popped = o_instr_pop;
			if (!i_instr_empty && !o_instr_pop)
				stall_count++;
			@(posedge CLK);
			#1;
			if (popped)
				void'(instr_q.pop_front());
			present_head();
		end
	end

	initial begin : commit_monitor
		commit_t exp;
		forever begin
			@(negedge CLK);
			if (dut.u_assertions.failures != 0)
				report_failure("a bound assertion on the back end failed");
			if (!i_reset && o_commit_valid === 1'b1) begin
				if (expected_q.size() == 0)
					report_failure("commit reported with no instruction outstanding");
				exp = expected_q.pop_front();
				check_equal("o_commit_rd", backend_pkg::XLEN'(o_commit_rd),
					backend_pkg::XLEN'(exp.rd));
				check_equal("o_commit_data", o_commit_data, exp.data);
				commit_count++;
			end
		end
	end

	// budget grows with the ops queued so far
	initial begin : watchdog
		forever begin
			@(posedge CLK);
			cycle_count++;
			if (cycle_count > sent_count * 40 + 1000)
				report_failure("watchdog expired before all queued ops committed");
		end
	end

	initial begin
		CLK           = 1'b0;
		i_reset       = 1'b1;
		i_instr_empty = 1'b1;
		i_op          = backend_pkg::OP_ADD;
		i_rd          = '0;
		i_rs1         = '0;
		i_rs2         = '0;
		i_imm         = '0;
		gaps_on       = 1'b0;
		for (int r = 0; r < backend_pkg::ARCH_REGS; r++)
			ref_regs[r] = '0;
		reset_dut();
		reset_reads_zero();
		opcode_results();
		raw_chain_values();
		copy_exhaust_stall();
		random_stream_match();
		check_equal("total commits", commit_count, sent_count);
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* compile.f */
design/backend_pkg.sv
design/dispatch.sv
design/issue_fifo.sv
design/alu_issue.sv
design/alu.sv
design/reorder_buffer.sv
design/commit.sv
design/phy_register.sv
design/back_end.sv
bench/back_end_assertions.sv
bench/tb_back_end.sv

/* design/alu.sv */
/*
 * Single-cycle integer ALU. The result and its destination copy
 * are registered for writeback into the physical register file.
 */
module alu (
	input  logic                          CLK,
	input  logic                          i_reset,
	input  logic                          i_exe_valid,
	input  backend_pkg::alu_op_e          i_exe_op,
	input  logic [backend_pkg::RA-1:0]    i_exe_rd,
	input  logic [backend_pkg::RB-1:0]    i_exe_rd_copy,
	input  logic [backend_pkg::XLEN-1:0]  i_exe_src1,
	input  logic [backend_pkg::XLEN-1:0]  i_exe_src2,
	input  logic [backend_pkg::IMM_W-1:0] i_exe_imm,
	output logic                          o_wb_valid,
	output logic [backend_pkg::RA-1:0]    o_wb_rd,
	output logic [backend_pkg::RB-1:0]    o_wb_copy,
	output logic [backend_pkg::XLEN-1:0]  o_wb_res
);

	logic [backend_pkg::XLEN-1:0] imm_ext;
	logic [backend_pkg::XLEN-1:0] result;

	assign imm_ext = {{(backend_pkg::XLEN - backend_pkg::IMM_W){i_exe_imm[backend_pkg::IMM_W-1]}},
	                  i_exe_imm};

	always_comb begin
		case (i_exe_op)
			backend_pkg::OP_ADD:  result = i_exe_src1 + i_exe_src2;
			backend_pkg::OP_SUB:  result = i_exe_src1 - i_exe_src2;
			backend_pkg::OP_AND:  result = i_exe_src1 & i_exe_src2;
			backend_pkg::OP_OR:   result = i_exe_src1 | i_exe_src2;
			backend_pkg::OP_XOR:  result = i_exe_src1 ^ i_exe_src2;
			backend_pkg::OP_ADDI: result = i_exe_src1 + imm_ext;
			default:              result = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (i_reset)
			o_wb_valid <= 1'b0;
		else
			o_wb_valid <= i_exe_valid;
	end

	always_ff @(posedge CLK) begin
		if (i_exe_valid) begin
			o_wb_rd   <= i_exe_rd;
			o_wb_copy <= i_exe_rd_copy;
			o_wb_res  <= result;
		end
	end

endmodule

/* design/alu_issue.sv */
/*
 * Issues the head of the ALU queue once its source copies are written,
 * and registers the operands read from the renamed register file.
 */
module alu_issue (
	input  logic                          CLK,
	input  logic                          i_reset,
	input  logic                          i_empty,
	input  backend_pkg::alu_op_e          i_op,
	input  logic [backend_pkg::RA-1:0]    i_rd,
	input  logic [backend_pkg::RB-1:0]    i_rd_copy,
	input  logic [backend_pkg::RA-1:0]    i_rs1,
	input  logic [backend_pkg::RB-1:0]    i_rs1_copy,
	input  logic [backend_pkg::RA-1:0]    i_rs2,
	input  logic [backend_pkg::RB-1:0]    i_rs2_copy,
	input  logic [backend_pkg::IMM_W-1:0] i_imm,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] i_wb_log,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] i_rn_buf,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0][backend_pkg::XLEN-1:0] i_reg_file,
	output logic                          o_pop,
	output logic                          o_exe_valid,
	output backend_pkg::alu_op_e          o_exe_op,
	output logic [backend_pkg::RA-1:0]    o_exe_rd,
	output logic [backend_pkg::RB-1:0]    o_exe_rd_copy,
	output logic [backend_pkg::XLEN-1:0]  o_exe_src1,
	output logic [backend_pkg::XLEN-1:0]  o_exe_src2,
	output logic [backend_pkg::IMM_W-1:0] o_exe_imm
);

	logic rs1_ready;
	logic rs2_ready;

	// written, or a copy no longer allocated
	assign rs1_ready = i_wb_log[i_rs1][i_rs1_copy] || !i_rn_buf[i_rs1][i_rs1_copy];
	assign rs2_ready = i_wb_log[i_rs2][i_rs2_copy] || !i_rn_buf[i_rs2][i_rs2_copy] ||
	                   (i_op == backend_pkg::OP_ADDI);

	// the ALU never stalls, so readiness alone decides
	assign o_pop = !i_empty && rs1_ready && rs2_ready;

	always_ff @(posedge CLK) begin
		if (i_reset)
			o_exe_valid <= 1'b0;
		else
			o_exe_valid <= o_pop;
	end

	always_ff @(posedge CLK) begin
		if (o_pop) begin
			o_exe_op      <= i_op;
			o_exe_rd      <= i_rd;
			o_exe_rd_copy <= i_rd_copy;
			o_exe_src1    <= i_reg_file[i_rs1][i_rs1_copy];
			o_exe_src2    <= i_reg_file[i_rs2][i_rs2_copy];
			o_exe_imm     <= i_imm;
		end
	end

endmodule

/* design/back_end.sv */
/*
 * Top level of the integer back end. Takes micro-ops from an external
 * instruction FIFO and reports every retirement in program order.
 */
module back_end (
	input  logic                             CLK,
	input  logic                             i_reset,
	input  logic                             i_instr_empty,
	input  backend_pkg::alu_op_e             i_op,
	input  logic [backend_pkg::RA-1:0]       i_rd,
	input  logic [backend_pkg::RA-1:0]       i_rs1,
	input  logic [backend_pkg::RA-1:0]       i_rs2,
	input  logic [backend_pkg::IMM_W-1:0]    i_imm,
	output logic                             o_instr_pop,
	output logic                             o_commit_valid,
	output logic [backend_pkg::RA-1:0]       o_commit_rd,
	output logic [backend_pkg::XLEN-1:0]     o_commit_data
);

	// rename state
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0][backend_pkg::XLEN-1:0] reg_file;
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RB-1:0] rn_act;
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] rn_buf;
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] wb_log;
	logic [backend_pkg::RP-1:0] rename_set;
	logic [backend_pkg::RP-1:0] commit_set;

	// reorder buffer
	logic                          rob_push;
	logic                          rob_pop;
	logic                          rob_full;
	logic                          rob_empty;
	logic [backend_pkg::RA-1:0]    rob_rd;
	logic [backend_pkg::RB-1:0]    rob_copy;
	logic [backend_pkg::RA-1:0]    head_rd;
	logic [backend_pkg::RB-1:0]    head_copy;

	// dispatch to issue FIFO, and FIFO head
	logic                          iq_push;
	logic                          iq_pop;
	logic                          iq_full;
	logic                          iq_empty;
	backend_pkg::alu_op_e          d_op;
	backend_pkg::alu_op_e          q_op;
	logic [backend_pkg::RA-1:0]    d_rd, d_rs1, d_rs2;
	logic [backend_pkg::RA-1:0]    q_rd, q_rs1, q_rs2;
	logic [backend_pkg::RB-1:0]    d_rd_copy, d_rs1_copy, d_rs2_copy;
	logic [backend_pkg::RB-1:0]    q_rd_copy, q_rs1_copy, q_rs2_copy;
	logic [backend_pkg::IMM_W-1:0] d_imm;
	logic [backend_pkg::IMM_W-1:0] q_imm;

	// execute and writeback
	logic                          exe_valid;
	backend_pkg::alu_op_e          exe_op;
	logic [backend_pkg::RA-1:0]    exe_rd;
	logic [backend_pkg::RB-1:0]    exe_rd_copy;
	logic [backend_pkg::XLEN-1:0]  exe_src1, exe_src2;
	logic [backend_pkg::IMM_W-1:0] exe_imm;
	logic                          wb_valid;
	logic [backend_pkg::RA-1:0]    wb_rd;
	logic [backend_pkg::RB-1:0]    wb_copy;
	logic [backend_pkg::XLEN-1:0]  wb_res;

	dispatch u_dispatch (
		.i_instr_empty(i_instr_empty), .i_op(i_op), .i_rd(i_rd), .i_rs1(i_rs1),
		.i_rs2(i_rs2), .i_imm(i_imm), .i_rn_act(rn_act), .i_rn_buf(rn_buf),
		.i_rob_full(rob_full), .i_iq_full(iq_full), .o_instr_pop(o_instr_pop),
		.o_rename_set(rename_set), .o_rob_push(rob_push), .o_rob_rd(rob_rd),
		.o_rob_copy(rob_copy), .o_iq_push(iq_push), .o_iq_op(d_op), .o_iq_rd(d_rd),
		.o_iq_rd_copy(d_rd_copy), .o_iq_rs1(d_rs1), .o_iq_rs1_copy(d_rs1_copy),
		.o_iq_rs2(d_rs2), .o_iq_rs2_copy(d_rs2_copy), .o_iq_imm(d_imm)
	);

	issue_fifo u_issue_fifo (
		.CLK(CLK), .i_reset(i_reset), .i_push(iq_push), .i_op(d_op), .i_rd(d_rd),
		.i_rd_copy(d_rd_copy), .i_rs1(d_rs1), .i_rs1_copy(d_rs1_copy), .i_rs2(d_rs2),
		.i_rs2_copy(d_rs2_copy), .i_imm(d_imm), .i_pop(iq_pop), .o_full(iq_full),
		.o_empty(iq_empty), .o_op(q_op), .o_rd(q_rd), .o_rd_copy(q_rd_copy),
		.o_rs1(q_rs1), .o_rs1_copy(q_rs1_copy), .o_rs2(q_rs2),
		.o_rs2_copy(q_rs2_copy), .o_imm(q_imm)
	);

	alu_issue u_alu_issue (
		.CLK(CLK), .i_reset(i_reset), .i_empty(iq_empty), .i_op(q_op), .i_rd(q_rd),
		.i_rd_copy(q_rd_copy), .i_rs1(q_rs1), .i_rs1_copy(q_rs1_copy), .i_rs2(q_rs2),
		.i_rs2_copy(q_rs2_copy), .i_imm(q_imm), .i_wb_log(wb_log), .i_rn_buf(rn_buf),
		.i_reg_file(reg_file), .o_pop(iq_pop), .o_exe_valid(exe_valid),
		.o_exe_op(exe_op), .o_exe_rd(exe_rd), .o_exe_rd_copy(exe_rd_copy),
		.o_exe_src1(exe_src1), .o_exe_src2(exe_src2), .o_exe_imm(exe_imm)
	);

	alu u_alu (
		.CLK(CLK), .i_reset(i_reset), .i_exe_valid(exe_valid), .i_exe_op(exe_op),
		.i_exe_rd(exe_rd), .i_exe_rd_copy(exe_rd_copy), .i_exe_src1(exe_src1),
		.i_exe_src2(exe_src2), .i_exe_imm(exe_imm), .o_wb_valid(wb_valid),
		.o_wb_rd(wb_rd), .o_wb_copy(wb_copy), .o_wb_res(wb_res)
	);

	reorder_buffer u_reorder_buffer (
		.CLK(CLK), .i_reset(i_reset), .i_push(rob_push), .i_rd(rob_rd),
		.i_copy(rob_copy), .i_pop(rob_pop), .o_full(rob_full), .o_empty(rob_empty),
		.o_head_rd(head_rd), .o_head_copy(head_copy)
	);

	commit u_commit (
		.CLK(CLK), .i_reset(i_reset), .i_rob_empty(rob_empty), .i_head_rd(head_rd),
		.i_head_copy(head_copy), .i_wb_log(wb_log), .i_reg_file(reg_file),
		.o_rob_pop(rob_pop), .o_commit_set(commit_set),
		.o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

	phy_register u_phy_register (
		.CLK(CLK), .i_reset(i_reset), .i_rename_set(rename_set), .i_rename_rd(rob_rd),
		.i_wb_valid(wb_valid), .i_wb_rd(wb_rd), .i_wb_copy(wb_copy), .i_wb_res(wb_res),
		.i_commit_set(commit_set), .i_commit_rd(head_rd), .o_reg_file(reg_file),
		.o_rn_act(rn_act), .o_rn_buf(rn_buf), .o_wb_log(wb_log)
	);

endmodule

/* design/backend_pkg.sv */
/*
 * Sizes and the ALU opcode set shared by every block of the back end.
 * Blocks refer to these through backend_pkg:: scoped names.
 */
package backend_pkg;

	// datapath and architectural register file
	localparam int XLEN      = 32;
	localparam int ARCH_REGS = 8;
	localparam int RA        = 3;

	// rename copies kept per architectural register
	localparam int RP = 4;
	localparam int RB = 2;

	// queue depths as address widths
	localparam int ROB_AW = 3;
	localparam int IQ_AW  = 2;

	// immediate is sign-extended to XLEN by the ALU
	localparam int IMM_W = 8;

	// OP_ADDI alone takes the immediate in place of rs2
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI
	} alu_op_e;

endpackage

/* design/commit.sv */
/*
 * Retires the oldest op once its copy is written back. The retirement
 * is reported on the outputs one cycle after the ROB pop.
 */
module commit (
	input  logic                         CLK,
	input  logic                         i_reset,
	input  logic                         i_rob_empty,
	input  logic [backend_pkg::RA-1:0]   i_head_rd,
	input  logic [backend_pkg::RB-1:0]   i_head_copy,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] i_wb_log,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0][backend_pkg::XLEN-1:0] i_reg_file,
	output logic                         o_rob_pop,
	output logic [backend_pkg::RP-1:0]   o_commit_set,
	output logic                         o_commit_valid,
	output logic [backend_pkg::RA-1:0]   o_commit_rd,
	output logic [backend_pkg::XLEN-1:0] o_commit_data
);

	assign o_rob_pop = !i_rob_empty && i_wb_log[i_head_rd][i_head_copy];

	// one-hot copy becoming architectural
	always_comb begin
		o_commit_set = '0;
		if (o_rob_pop)
			o_commit_set[i_head_copy] = 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (i_reset)
			o_commit_valid <= 1'b0;
		else
			o_commit_valid <= o_rob_pop;
	end

	always_ff @(posedge CLK) begin
		if (o_rob_pop) begin
			o_commit_rd   <= i_head_rd;
			o_commit_data <= i_reg_file[i_head_rd][i_head_copy];
		end
	end

endmodule

/* design/dispatch.sv */
/*
 * Renames the destination of the incoming micro-op and sends it to the
 * reorder buffer and the ALU issue FIFO in the same cycle.
 */
module dispatch (
	input  logic                             i_instr_empty,
	input  backend_pkg::alu_op_e             i_op,
	input  logic [backend_pkg::RA-1:0]       i_rd,
	input  logic [backend_pkg::RA-1:0]       i_rs1,
	input  logic [backend_pkg::RA-1:0]       i_rs2,
	input  logic [backend_pkg::IMM_W-1:0]    i_imm,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RB-1:0] i_rn_act,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] i_rn_buf,
	input  logic                             i_rob_full,
	input  logic                             i_iq_full,
	output logic                             o_instr_pop,
	output logic [backend_pkg::RP-1:0]       o_rename_set,
	output logic                             o_rob_push,
	output logic [backend_pkg::RA-1:0]       o_rob_rd,
	output logic [backend_pkg::RB-1:0]       o_rob_copy,
	output logic                             o_iq_push,
	output backend_pkg::alu_op_e             o_iq_op,
	output logic [backend_pkg::RA-1:0]       o_iq_rd,
	output logic [backend_pkg::RB-1:0]       o_iq_rd_copy,
	output logic [backend_pkg::RA-1:0]       o_iq_rs1,
	output logic [backend_pkg::RB-1:0]       o_iq_rs1_copy,
	output logic [backend_pkg::RA-1:0]       o_iq_rs2,
	output logic [backend_pkg::RB-1:0]       o_iq_rs2_copy,
	output logic [backend_pkg::IMM_W-1:0]    o_iq_imm
);

	logic                       free_found;
	logic [backend_pkg::RB-1:0] free_copy;
	logic                       fire;

	// lowest unallocated copy of rd, scanned from the top so bit 0 wins
	always_comb begin
		free_found = 1'b0;
		free_copy  = '0;
		for (int i = backend_pkg::RP - 1; i >= 0; i--) begin
			if (!i_rn_buf[i_rd][i]) begin
				free_found = 1'b1;
				free_copy  = i[backend_pkg::RB-1:0];
			end
		end
	end

	assign fire = !i_instr_empty && !i_rob_full && !i_iq_full && free_found;

	always_comb begin
		o_rename_set = '0;
		if (fire)
			o_rename_set[free_copy] = 1'b1;
	end

	assign o_instr_pop = fire;
	assign o_rob_push  = fire;
	assign o_iq_push   = fire;
	assign o_rob_rd    = i_rd;
	assign o_rob_copy  = free_copy;

	// sources see the mapping before this op's own rename
	assign o_iq_op       = i_op;
	assign o_iq_rd       = i_rd;
	assign o_iq_rd_copy  = free_copy;
	assign o_iq_rs1      = i_rs1;
	assign o_iq_rs1_copy = i_rn_act[i_rs1];
	assign o_iq_rs2      = i_rs2;
	assign o_iq_rs2_copy = i_rn_act[i_rs2];
	assign o_iq_imm      = i_imm;

endmodule

/* design/issue_fifo.sv */
/*
 * In-order queue of renamed ALU ops between dispatch and issue.
 * The head entry is presented combinationally while the queue is not empty.
 */
module issue_fifo (
	input  logic                          CLK,
	input  logic                          i_reset,
	input  logic                          i_push,
	input  backend_pkg::alu_op_e          i_op,
	input  logic [backend_pkg::RA-1:0]    i_rd,
	input  logic [backend_pkg::RB-1:0]    i_rd_copy,
	input  logic [backend_pkg::RA-1:0]    i_rs1,
	input  logic [backend_pkg::RB-1:0]    i_rs1_copy,
	input  logic [backend_pkg::RA-1:0]    i_rs2,
	input  logic [backend_pkg::RB-1:0]    i_rs2_copy,
	input  logic [backend_pkg::IMM_W-1:0] i_imm,
	input  logic                          i_pop,
	output logic                          o_full,
	output logic                          o_empty,
	output backend_pkg::alu_op_e          o_op,
	output logic [backend_pkg::RA-1:0]    o_rd,
	output logic [backend_pkg::RB-1:0]    o_rd_copy,
	output logic [backend_pkg::RA-1:0]    o_rs1,
	output logic [backend_pkg::RB-1:0]    o_rs1_copy,
	output logic [backend_pkg::RA-1:0]    o_rs2,
	output logic [backend_pkg::RB-1:0]    o_rs2_copy,
	output logic [backend_pkg::IMM_W-1:0] o_imm
);

	localparam int REGS_W = 3 * (backend_pkg::RA + backend_pkg::RB);

	backend_pkg::alu_op_e          op_mem   [2**backend_pkg::IQ_AW];
	logic [REGS_W-1:0]             regs_mem [2**backend_pkg::IQ_AW];
	logic [backend_pkg::IMM_W-1:0] imm_mem  [2**backend_pkg::IQ_AW];

	// one extra pointer bit tells full from empty
	logic [backend_pkg::IQ_AW:0] wr_ptr;
	logic [backend_pkg::IQ_AW:0] rd_ptr;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[backend_pkg::IQ_AW] != rd_ptr[backend_pkg::IQ_AW]) &&
	                 (wr_ptr[backend_pkg::IQ_AW-1:0] == rd_ptr[backend_pkg::IQ_AW-1:0]);

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_push) begin
			op_mem[wr_ptr[backend_pkg::IQ_AW-1:0]]   <= i_op;
			regs_mem[wr_ptr[backend_pkg::IQ_AW-1:0]] <=
				{i_rd, i_rd_copy, i_rs1, i_rs1_copy, i_rs2, i_rs2_copy};
			imm_mem[wr_ptr[backend_pkg::IQ_AW-1:0]]  <= i_imm;
		end
	end

	assign o_op  = op_mem[rd_ptr[backend_pkg::IQ_AW-1:0]];
	assign o_imm = imm_mem[rd_ptr[backend_pkg::IQ_AW-1:0]];
	assign {o_rd, o_rd_copy, o_rs1, o_rs1_copy, o_rs2, o_rs2_copy} =
		regs_mem[rd_ptr[backend_pkg::IQ_AW-1:0]];

endmodule

/* design/phy_register.sv */
/*
 * Renamed register copies with their active and architectural mappings,
 * allocation bits and writeback log. Updated by rename, writeback and commit.
 */
module phy_register (
	input  logic                         CLK,
	input  logic                         i_reset,
	input  logic [backend_pkg::RP-1:0]   i_rename_set,
	input  logic [backend_pkg::RA-1:0]   i_rename_rd,
	input  logic                         i_wb_valid,
	input  logic [backend_pkg::RA-1:0]   i_wb_rd,
	input  logic [backend_pkg::RB-1:0]   i_wb_copy,
	input  logic [backend_pkg::XLEN-1:0] i_wb_res,
	input  logic [backend_pkg::RP-1:0]   i_commit_set,
	input  logic [backend_pkg::RA-1:0]   i_commit_rd,
	output logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0][backend_pkg::XLEN-1:0] o_reg_file,
	output logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RB-1:0] o_rn_act,
	output logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] o_rn_buf,
	output logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] o_wb_log
);

	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RB-1:0] archi;
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] rn_buf_next;
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::RP-1:0] wb_log_next;
	logic [backend_pkg::RB-1:0] rename_copy;
	logic [backend_pkg::RB-1:0] commit_copy;

	function automatic logic [backend_pkg::RB-1:0] onehot_idx(
		input logic [backend_pkg::RP-1:0] oh
	);
		logic [backend_pkg::RB-1:0] idx;
		idx = '0;
		for (int i = 0; i < backend_pkg::RP; i++) begin
			if (oh[i])
				idx = i[backend_pkg::RB-1:0];
		end
		return idx;
	endfunction

	assign rename_copy = onehot_idx(i_rename_set);
	assign commit_copy = onehot_idx(i_commit_set);

	// the three updates never touch the same copy in one cycle
	always_comb begin
		rn_buf_next = o_rn_buf;
		wb_log_next = o_wb_log;
		rn_buf_next[i_rename_rd] = o_rn_buf[i_rename_rd] | i_rename_set;
		wb_log_next[i_rename_rd] = o_wb_log[i_rename_rd] & ~i_rename_set;
		if (i_wb_valid)
			wb_log_next[i_wb_rd][i_wb_copy] = 1'b1;
		// release the copy that was architectural until now
		if (|i_commit_set) begin
			rn_buf_next[i_commit_rd][archi[i_commit_rd]] = 1'b0;
			wb_log_next[i_commit_rd][archi[i_commit_rd]] = 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			o_reg_file <= '0;
			o_rn_act   <= '0;
			archi      <= '0;
			// copy 0 of every register starts allocated and written
			for (int r = 0; r < backend_pkg::ARCH_REGS; r++) begin
				o_rn_buf[r] <= backend_pkg::RP'(1);
				o_wb_log[r] <= backend_pkg::RP'(1);
			end
		end else begin
			if (|i_rename_set)
				o_rn_act[i_rename_rd] <= rename_copy;
			if (i_wb_valid)
				o_reg_file[i_wb_rd][i_wb_copy] <= i_wb_res;
			if (|i_commit_set)
				archi[i_commit_rd] <= commit_copy;
			o_rn_buf <= rn_buf_next;
			o_wb_log <= wb_log_next;
		end
	end

endmodule

/* design/reorder_buffer.sv */
/*
 * Program-order circular buffer of in-flight destinations.
 * Dispatch pushes at the tail and commit retires from the head.
 */
module reorder_buffer (
	input  logic                       CLK,
	input  logic                       i_reset,
	input  logic                       i_push,
	input  logic [backend_pkg::RA-1:0] i_rd,
	input  logic [backend_pkg::RB-1:0] i_copy,
	input  logic                       i_pop,
	output logic                       o_full,
	output logic                       o_empty,
	output logic [backend_pkg::RA-1:0] o_head_rd,
	output logic [backend_pkg::RB-1:0] o_head_copy
);

	logic [backend_pkg::RA-1:0] rd_mem   [2**backend_pkg::ROB_AW];
	logic [backend_pkg::RB-1:0] copy_mem [2**backend_pkg::ROB_AW];

	logic [backend_pkg::ROB_AW:0] tail;
	logic [backend_pkg::ROB_AW:0] head;

	assign o_empty = (tail == head);
	assign o_full  = (tail[backend_pkg::ROB_AW] != head[backend_pkg::ROB_AW]) &&
	                 (tail[backend_pkg::ROB_AW-1:0] == head[backend_pkg::ROB_AW-1:0]);

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			tail <= '0;
			head <= '0;
		end else begin
			if (i_push)
				tail <= tail + 1'b1;
			if (i_pop)
				head <= head + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_push) begin
			rd_mem[tail[backend_pkg::ROB_AW-1:0]]   <= i_rd;
			copy_mem[tail[backend_pkg::ROB_AW-1:0]] <= i_copy;
		end
	end

	assign o_head_rd   = rd_mem[head[backend_pkg::ROB_AW-1:0]];
	assign o_head_copy = copy_mem[head[backend_pkg::ROB_AW-1:0]];

endmodule
